// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert -f src.f --top-module fetchStage3Tb -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== sim/fetchStage3Tb.sv ====
`timescale 1ns/1ps
`include "fetchStage_defs.svh"

module fetchStage3Tb import fetchPkg::*; ();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 4;
    localparam int numCycles   = 3000;
    localparam int dogCycles   = numCycles + 100; // numCycles plus margin

    logic clk, rst, flush, pause;
    addrT pc [2];
    instT inst [2];
    logic valid [2];
    logic nlpValid [2];
    logic nlpTaken [2];
    addrT nlpTarget [2];
    bimT  nlpBim [2];
    logic predValid;
    logic predTaken;
    addrT predTarget;

    logic isJ0, isBr0, predTaken0, outValid0;
    logic isJ1, isBr1, predTaken1, outValid1;
    addrT predAddr0, predAddr1;
    logic isBranch, redirect, nlpUpdValid, nlpUpdTake;
    addrT redirectPc, nlpUpdPc, nlpUpdTarget;
    bimT  nlpUpdBim;

    logic mWait;                            // model of the delay-slot wait state
    addrT mTarget;
    logic nWait;
    addrT nTarget;
    int   errors;
    int   checks;
    int   cyc;

    fetchStage3 i_fetchStage3 (
        .clk(clk), .rst(rst), .flush(flush), .pause(pause),
        .pc0(pc[0]), .inst0(inst[0]), .valid0(valid[0]), .nlpValid0(nlpValid[0]),
        .nlpTaken0(nlpTaken[0]), .nlpTarget0(nlpTarget[0]), .nlpBim0(nlpBim[0]),
        .pc1(pc[1]), .inst1(inst[1]), .valid1(valid[1]), .nlpValid1(nlpValid[1]),
        .nlpTaken1(nlpTaken[1]), .nlpTarget1(nlpTarget[1]), .nlpBim1(nlpBim[1]),
        .predValid(predValid), .predTaken(predTaken), .predTarget(predTarget),
        .isJ0(isJ0), .isBr0(isBr0), .predTaken0(predTaken0), .predAddr0(predAddr0),
        .outValid0(outValid0),
        .isJ1(isJ1), .isBr1(isBr1), .predTaken1(predTaken1), .predAddr1(predAddr1),
        .outValid1(outValid1),
        .isBranch(isBranch), .redirect(redirect), .redirectPc(redirectPc),
        .nlpUpdValid(nlpUpdValid), .nlpUpdPc(nlpUpdPc), .nlpUpdTarget(nlpUpdTarget),
        .nlpUpdBim(nlpUpdBim), .nlpUpdTake(nlpUpdTake)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkBim(input string name, input bimT got, input bimT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // opcode rules for one slot
    task automatic decodeSlot(input addrT pcIn, input instT word, input logic v,
                              output logic j, output logic jr, output logic br,
                              output addrT tgt);
        logic [5:0] op;
        addrT       next;
        op   = word[31:26];
        next = pcIn + 32'd4;
        j    = 1'b0;
        jr   = 1'b0;
        br   = 1'b0;
        tgt  = '0;
        if (v && (op == `OP_J || op == `OP_JAL)) begin
            j   = 1'b1;
            tgt = {next[31:28], word[25:0], 2'b00};
        end else if (v && op == `OP_SPECIAL &&
                     (word[5:0] == `FN_JR || word[5:0] == `FN_JALR)) begin
            j  = 1'b1;
            jr = 1'b1;
        end else if (v && op inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM}) begin
            br  = 1'b1;
            tgt = next + {{14{word[15]}}, word[15:0], 2'b00};
        end
    endtask

    // BPD first, NLP second
    task automatic predictSlot(input logic j, input logic jr, input logic br, input addrT tgt,
                               input logic nv, input logic nt, input addrT ntgt,
                               output logic tk, output addrT addr);
        tk   = 1'b0;
        addr = '0;
        if (j && !jr) begin
            tk   = 1'b1;
            addr = tgt;
        end else if (jr && predValid) begin
            tk   = 1'b1;
            addr = predTarget;
        end else if (jr && nv) begin
            tk   = 1'b1;
            addr = ntgt;
        end else if (br) begin
            addr = tgt;
            tk   = predValid ? predTaken : (nv && nt);
        end
    endtask

    function automatic instT genInst();
        int         kind;
        int         off;
        logic [5:0] op;
        kind = int'($urandom % 12);
        off  = int'($urandom % 64) - 32;    // short branch distance
        if (kind == 0) begin
            op = ($urandom % 2 == 0) ? `OP_J : `OP_JAL;
            return {op, 26'($urandom)};
        end else if (kind == 1) begin
            return {`OP_SPECIAL, 20'($urandom), ($urandom % 2 == 0) ? `FN_JR : `FN_JALR};
        end else if (kind <= 3) begin
            op = 6'(3 + $urandom % 5);
            if (op == 6'd3) begin
                op = `OP_REGIMM;
            end
            return {op, 10'($urandom), 16'(off)};
        end else if (kind == 4) begin
            return {`OP_SPECIAL, 20'($urandom), 6'h20 + 6'($urandom % 4)}; // alu ops
        end
        op = 6'(8 + $urandom % 56);
        return {op, 26'($urandom)};
    endfunction

    task automatic idleInputs();
        int i;
        flush      <= 1'b0;
        pause      <= 1'b0;
        predValid  <= 1'b0;
        predTaken  <= 1'b0;
        predTarget <= '0;
        for (i = 0; i < 2; i++) begin
            pc[i]        <= '0;
            inst[i]      <= '0;
            valid[i]     <= 1'b0;
            nlpValid[i]  <= 1'b0;
            nlpTaken[i]  <= 1'b0;
            nlpTarget[i] <= '0;
            nlpBim[i]    <= '0;
        end
    endtask

    task automatic driveRandom();
        addrT base;
        addrT bpdTgt;
        instT word;
        logic j;
        logic jr;
        logic br;
        addrT stat;
        int   r;
        int   i;
        base   = $urandom & 32'hFFFF_FFFC;
        bpdTgt = $urandom & 32'hFFFF_FFFC;
        flush      <= ($urandom % 40) == 0;
        pause      <= ($urandom % 25) == 0;
        predValid  <= ($urandom % 2) == 0;
        predTaken  <= ($urandom % 2) == 0;
        predTarget <= bpdTgt;
        for (i = 0; i < 2; i++) begin
            word = genInst();
            decodeSlot(base + addrT'(4 * i), word, 1'b1, j, jr, br, stat);
            r = int'($urandom % 3);         // nlp target often agrees
            pc[i]        <= base + addrT'(4 * i);
            inst[i]      <= word;
            valid[i]     <= ($urandom % 10) != 0;
            nlpValid[i]  <= ($urandom % 2) == 0;
            nlpTaken[i]  <= ($urandom % 2) == 0;
            nlpTarget[i] <= (r == 0) ? stat : (r == 1) ? bpdTgt : ($urandom & 32'hFFFF_FFFC);
            nlpBim[i]    <= bimT'($urandom);
        end
    endtask

    task automatic checkCycle();
        logic eJ [2];
        logic eJr [2];
        logic eBr [2];
        addrT eTgt [2];
        logic eTk [2];
        addrT eAddr [2];
        logic miss [2];
        addrT corr [2];
        logic upd [2];
        logic nlpEff;
        logic eRedir;
        addrT eRedirPc;
        int   i;
        int   u;
        for (i = 0; i < 2; i++) begin
            decodeSlot(pc[i], inst[i], valid[i], eJ[i], eJr[i], eBr[i], eTgt[i]);
            predictSlot(eJ[i], eJr[i], eBr[i], eTgt[i], nlpValid[i], nlpTaken[i],
                        nlpTarget[i], eTk[i], eAddr[i]);
            nlpEff  = valid[i] && nlpValid[i] && nlpTaken[i];
            miss[i] = (eTk[i] != nlpEff) || (eTk[i] && nlpEff && eAddr[i] != nlpTarget[i]);
            corr[i] = eTk[i] ? eAddr[i] : pc[i] + addrT'(`FALLTHRU);
            upd[i]  = valid[i] && ((predValid && (eJ[i] || eBr[i])) || (eJ[i] && !eJr[i]) ||
                                   (eJr[i] && nlpValid[i]));
        end
        eRedir   = 1'b0;
        eRedirPc = '0;
        nWait    = mWait;
        nTarget  = mTarget;
        if (!rst && !flush && !pause) begin
            if (mWait) begin
                eRedir   = valid[0];        // delay slot has arrived
                eRedirPc = mTarget;
                nWait    = mWait && !valid[0];
            end else if (miss[0]) begin
                eRedir   = 1'b1;
                eRedirPc = corr[0];
            end else if (miss[1] && (eJ[1] || eBr[1])) begin
                nWait   = 1'b1;
                nTarget = corr[1];
            end
        end
        if (rst || flush) begin
            nWait = 1'b0;
        end
        checkBit("isJ0", isJ0, eJ[0]);
        checkBit("isBr0", isBr0, eBr[0]);
        checkBit("predTaken0", predTaken0, eTk[0]);
        checkAddr("predAddr0", predAddr0, eAddr[0]);
        checkBit("outValid0", outValid0, valid[0]);
        checkBit("isJ1", isJ1, eJ[1]);
        checkBit("isBr1", isBr1, eBr[1]);
        checkBit("predTaken1", predTaken1, eTk[1]);
        checkAddr("predAddr1", predAddr1, eAddr[1]);
        checkBit("outValid1", outValid1, valid[1] && !mWait);
        checkBit("isBranch", isBranch, eJ[0] || eBr[0] || eJ[1] || eBr[1]);
        checkBit("redirect", redirect, eRedir);
        if (eRedir) begin
            checkAddr("redirectPc", redirectPc, eRedirPc);
        end
        checkBit("nlpUpdValid", nlpUpdValid, upd[0] || upd[1]);
        if (upd[0] || upd[1]) begin
            u = upd[0] ? 0 : 1;             // older slot first
            checkAddr("nlpUpdPc", nlpUpdPc, pc[u]);
            checkAddr("nlpUpdTarget", nlpUpdTarget, eAddr[u]);
            checkBit("nlpUpdTake", nlpUpdTake, eTk[u]);
            checkBim("nlpUpdBim", nlpUpdBim, nlpValid[u] ? nlpBim[u] : bimT'(1));
        end
    endtask

    initial begin
        #(dogCycles * clkPeriod);
        $display("watchdog expired before the test loop finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(86344));
        clk     = 1'b0;
        rst     = 1'b1;
        errors  = 0;
        checks  = 0;
        nWait   = 1'b0;
        nTarget = '0;
        idleInputs();
        for (cyc = 0; cyc < resetCycles + numCycles; cyc++) begin
            @(posedge clk);
            mWait   = nWait;
            mTarget = nTarget;
            if (cyc < resetCycles) begin
                rst <= 1'b1;
                idleInputs();
            end else begin
                rst <= 1'b0;
                driveRandom();
            end
            @(negedge clk);
            checkCycle();
        end
        $display("checked %0d values, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim/fetchStage3_sva.sv ====
`timescale 1ns/1ps

module fetchStage3Sva import fetchPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    flush,
    input logic    pause,
    input logic    redirect,
    input logic    slot1Valid,
    input dsStateT waitDs
);

    noRedirectHeld: assert property (@(posedge clk) (flush || pause) |-> !redirect)
        else $error("redirect raised while flush or pause was high");

    noRedirectInReset: assert property (@(posedge clk) rst |-> !redirect)
        else $error("redirect raised during reset");

    // wait left without flush or reset means the held redirect went out
    leaveWaitRedirects: assert property (@(posedge clk)
        (waitDs == DS_IDLE && $past(waitDs) == DS_WAIT && !$past(flush) && !$past(rst))
            |-> $past(redirect))
        else $error("delay-slot wait ended without a redirect");

    slot1HiddenInWait: assert property (@(posedge clk) (waitDs == DS_WAIT) |-> !slot1Valid)
        else $error("slot 1 valid while waiting for the delay slot");

endmodule

bind redirectCtrl fetchStage3Sva i_fetchStage3Sva (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .pause      (pause),
    .redirect   (redirect),
    .slot1Valid (slot1Valid),
    .waitDs     (waitDs)
);

// ==== src.f ====
+incdir+src
src/fetchPkg.sv
src/fetchSlotIf.sv
src/predecoder.sv
src/predictSelect.sv
src/redirectCtrl.sv
src/fetchStage3.sv
sim/fetchStage3_sva.sv
sim/fetchStage3Tb.sv

// ==== src/fetchPkg.sv ====
`include "fetchStage_defs.svh"

package fetchPkg;

    typedef logic [`ADDR_W-1:0] addrT;     // fetch address
    typedef logic [`INST_W-1:0] instT;     // raw instruction word

    // NLP two-bit counter
    // 0 strongly not taken up to 3 strongly taken
    typedef logic [1:0] bimT;

    typedef enum logic {
        DS_IDLE,                            // nothing pending
        DS_WAIT                             // slot 1 redirect held for its delay slot
    } dsStateT;

endpackage

// ==== src/fetchSlotIf.sv ====
`timescale 1ns/1ps

interface fetchSlotIf import fetchPkg::*; ();

    addrT pc;
    instT inst;
    logic valid;
    logic nlpValid;                         // NLP had an entry for this pc
    logic nlpTaken;
    addrT nlpTarget;
    bimT  nlpBim;

    logic isJ;                              // includes jr and jalr
    logic isJr;
    logic isBr;
    addrT target;                           // static target from predecode

    logic predTaken;
    addrT predAddr;

    modport decode (
        input  pc, inst, valid,
        output isJ, isJr, isBr, target
    );

    modport execute (
        input  isJ, isJr, isBr, target,
        input  nlpValid, nlpTaken, nlpTarget,
        output predTaken, predAddr
    );

    modport result (
        input pc, inst, valid, nlpValid, nlpTaken, nlpTarget, nlpBim,
        input isJ, isJr, isBr, target, predTaken, predAddr
    );

endinterface

// ==== src/fetchStage3.sv ====
`timescale 1ns/1ps

module fetchStage3 import fetchPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic pause,
    input  addrT pc0,
    input  instT inst0,
    input  logic valid0,
    input  logic nlpValid0,
    input  logic nlpTaken0,
    input  addrT nlpTarget0,
    input  bimT  nlpBim0,
    input  addrT pc1,
    input  instT inst1,
    input  logic valid1,
    input  logic nlpValid1,
    input  logic nlpTaken1,
    input  addrT nlpTarget1,
    input  bimT  nlpBim1,
    input  logic predValid,                 // from BPD, shared by both slots
    input  logic predTaken,
    input  addrT predTarget,
    output logic isJ0,
    output logic isBr0,
    output logic predTaken0,
    output addrT predAddr0,
    output logic outValid0,
    output logic isJ1,
    output logic isBr1,
    output logic predTaken1,
    output addrT predAddr1,
    output logic outValid1,
    output logic isBranch,                  // to BPD global history
    output logic redirect,
    output addrT redirectPc,
    output logic nlpUpdValid,
    output addrT nlpUpdPc,
    output addrT nlpUpdTarget,
    output bimT  nlpUpdBim,
    output logic nlpUpdTake
);

    fetchSlotIf slot0 ();
    fetchSlotIf slot1 ();

    assign slot0.pc        = pc0;
    assign slot0.inst      = inst0;
    assign slot0.valid     = valid0;
    assign slot0.nlpValid  = nlpValid0;
    assign slot0.nlpTaken  = nlpTaken0;
    assign slot0.nlpTarget = nlpTarget0;
    assign slot0.nlpBim    = nlpBim0;

    assign slot1.pc        = pc1;
    assign slot1.inst      = inst1;
    assign slot1.valid     = valid1;
    assign slot1.nlpValid  = nlpValid1;
    assign slot1.nlpTaken  = nlpTaken1;
    assign slot1.nlpTarget = nlpTarget1;
    assign slot1.nlpBim    = nlpBim1;

    predecoder i_predecoder0 (.s(slot0.decode));
    predecoder i_predecoder1 (.s(slot1.decode));

    predictSelect i_predictSelect0 (
        .s          (slot0.execute),
        .predValid  (predValid),
        .predTaken  (predTaken),
        .predTarget (predTarget)
    );

    predictSelect i_predictSelect1 (
        .s          (slot1.execute),
        .predValid  (predValid),
        .predTaken  (predTaken),
        .predTarget (predTarget)
    );

    redirectCtrl i_redirectCtrl (
        .s0           (slot0.result),
        .s1           (slot1.result),
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .pause        (pause),
        .predValid    (predValid),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .slot1Valid   (outValid1),
        .nlpUpdValid  (nlpUpdValid),
        .nlpUpdPc     (nlpUpdPc),
        .nlpUpdTarget (nlpUpdTarget),
        .nlpUpdBim    (nlpUpdBim),
        .nlpUpdTake   (nlpUpdTake)
    );

    assign isJ0       = slot0.isJ;
    assign isBr0      = slot0.isBr;
    assign predTaken0 = slot0.predTaken;
    assign predAddr0  = slot0.predAddr;
    assign outValid0  = valid0;
    assign isJ1       = slot1.isJ;
    assign isBr1      = slot1.isBr;
    assign predTaken1 = slot1.predTaken;
    assign predAddr1  = slot1.predAddr;
    assign isBranch   = slot0.isJ | slot0.isBr | slot1.isJ | slot1.isBr;

endmodule

// ==== src/fetchStage_defs.svh ====
`ifndef FETCHSTAGE_DEFS_SVH
`define FETCHSTAGE_DEFS_SVH

`define ADDR_W      32
`define INST_W      32

// pc of a control instruction to the one after its delay slot
`define FALLTHRU    8

// primary opcodes, inst[31:26]
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111

// SPECIAL function codes, inst[5:0]
`define FN_JR       6'b001000
`define FN_JALR     6'b001001

`endif

// ==== src/predecoder.sv ====
`timescale 1ns/1ps
`include "fetchStage_defs.svh"

module predecoder import fetchPkg::*; (
    fetchSlotIf.decode s
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic [25:0] index;
    addrT        pcPlus4;
    addrT        brOffset;

    assign opcode  = s.inst[31:26];
    assign funct   = s.inst[5:0];
    assign imm     = s.inst[15:0];
    assign index   = s.inst[25:0];
    assign pcPlus4 = s.pc + addrT'(4);

    // sign extended word offset
    assign brOffset = {{(`ADDR_W-18){imm[15]}}, imm, 2'b00};

    always_comb begin
        s.isJ    = 1'b0;
        s.isJr   = 1'b0;
        s.isBr   = 1'b0;
        s.target = '0;
        if (s.valid) begin
            case (opcode)
                `OP_J, `OP_JAL: begin
                    s.isJ    = 1'b1;
                    s.target = {pcPlus4[`ADDR_W-1:`ADDR_W-4], index, 2'b00}; // region of delay slot
                end
                `OP_SPECIAL: begin
                    if (funct == `FN_JR || funct == `FN_JALR) begin
                        s.isJ  = 1'b1;
                        s.isJr = 1'b1;              // target only known at execute
                    end
                end
                `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM: begin
                    s.isBr   = 1'b1;
                    s.target = pcPlus4 + brOffset;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== src/predictSelect.sv ====
`timescale 1ns/1ps

module predictSelect import fetchPkg::*; (
    fetchSlotIf.execute s,
    input  logic        predValid,
    input  logic        predTaken,
    input  addrT        predTarget
);

    logic isDirectJ;

    assign isDirectJ = s.isJ && !s.isJr;

    always_comb begin
        s.predTaken = 1'b0;
        s.predAddr  = '0;
        if (s.isJr) begin
            // BPD first, then NLP
            if (predValid) begin
                s.predTaken = 1'b1;
                s.predAddr  = predTarget;
            end else if (s.nlpValid) begin
                s.predTaken = 1'b1;
                s.predAddr  = s.nlpTarget;
            end
        end else if (isDirectJ) begin
            s.predTaken = 1'b1;                 // always taken
            s.predAddr  = s.target;
        end else if (s.isBr) begin
            s.predAddr = s.target;              // direction only is predicted
            if (predValid) begin
                s.predTaken = predTaken;
            end else if (s.nlpValid) begin
                s.predTaken = s.nlpTaken;
            end
        end
    end

endmodule

// ==== src/redirectCtrl.sv ====
`timescale 1ns/1ps
`include "fetchStage_defs.svh"

module redirectCtrl import fetchPkg::*; (
    fetchSlotIf.result s0,
    fetchSlotIf.result s1,
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        pause,
    input  logic        predValid,
    output logic        redirect,
    output addrT        redirectPc,
    output logic        slot1Valid,
    output logic        nlpUpdValid,
    output addrT        nlpUpdPc,
    output addrT        nlpUpdTarget,
    output bimT         nlpUpdBim,
    output logic        nlpUpdTake
);

    dsStateT waitDs;
    dsStateT waitDsNext;
    addrT    waitTarget;                    // slot 1 correction held for later
    logic    enterWait;
    logic    nlpTk0;
    logic    nlpTk1;
    logic    miss0;
    logic    miss1;
    addrT    corr0;
    addrT    corr1;
    logic    upd0;
    logic    upd1;

    function automatic logic slotMiss(input logic predTk, input logic nlpTk,
                                      input addrT predAddr, input addrT nlpTarget);
        return (predTk != nlpTk) || (predTk && nlpTk && predAddr != nlpTarget);
    endfunction

    function automatic logic slotUpd(input logic valid, input logic isJ, input logic isJr,
                                     input logic isBr, input logic nlpValid);
        return valid && ((predValid && (isJ || isBr)) || (isJ && !isJr) ||
                         (isJr && nlpValid));
    endfunction

    assign nlpTk0 = s0.valid && s0.nlpValid && s0.nlpTaken;
    assign nlpTk1 = s1.valid && s1.nlpValid && s1.nlpTaken;
    assign miss0  = slotMiss(s0.predTaken, nlpTk0, s0.predAddr, s0.nlpTarget);
    assign miss1  = slotMiss(s1.predTaken, nlpTk1, s1.predAddr, s1.nlpTarget);
    assign corr0  = s0.predTaken ? s0.predAddr : s0.pc + addrT'(`FALLTHRU);
    assign corr1  = s1.predTaken ? s1.predAddr : s1.pc + addrT'(`FALLTHRU);

    always_comb begin
        redirect   = 1'b0;
        redirectPc = '0;
        waitDsNext = waitDs;
        enterWait  = 1'b0;
        if (!rst && !flush && !pause) begin
            if (waitDs == DS_WAIT) begin
                redirect   = s0.valid;          // delay slot has arrived
                redirectPc = waitTarget;
                if (s0.valid) begin
                    waitDsNext = DS_IDLE;
                end
            end else if (miss0) begin
                redirect   = 1'b1;
                redirectPc = corr0;
            end else if (miss1 && (s1.isJ || s1.isBr)) begin
                waitDsNext = DS_WAIT;
                enterWait  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            waitDs <= DS_IDLE;
        end else begin
            waitDs <= waitDsNext;
        end
        if (enterWait) begin
            waitTarget <= corr1;
        end
    end

    assign slot1Valid = s1.valid && (waitDs != DS_WAIT);

    assign upd0 = slotUpd(s0.valid, s0.isJ, s0.isJr, s0.isBr, s0.nlpValid);
    assign upd1 = slotUpd(s1.valid, s1.isJ, s1.isJr, s1.isBr, s1.nlpValid);

    // older slot wins the single training port
    always_comb begin
        nlpUpdValid  = 1'b0;
        nlpUpdPc     = '0;
        nlpUpdTarget = '0;
        nlpUpdBim    = '0;
        nlpUpdTake   = 1'b0;
        if (upd0) begin
            nlpUpdValid  = 1'b1;
            nlpUpdPc     = s0.pc;
            nlpUpdTarget = s0.predAddr;
            nlpUpdBim    = s0.nlpValid ? s0.nlpBim : bimT'(2'b01); // weakly not taken
            nlpUpdTake   = s0.predTaken;
        end else if (upd1) begin
            nlpUpdValid  = 1'b1;
            nlpUpdPc     = s1.pc;
            nlpUpdTarget = s1.predAddr;
            nlpUpdBim    = s1.nlpValid ? s1.nlpBim : bimT'(2'b01);
            nlpUpdTake   = s1.predTaken;
        end
    end

endmodule
